// File: logic/exec_cfg.svh
//////////////////////////////////////////////////
// Execute stage configuration macros
// Word width, IA-32 flag positions, stack slot
//////////////////////////////////////////////////
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data and address word width
`define EXEC_XLEN 32

// Flag bit positions in the IA-32 layout
`define EXEC_CF 0
`define EXEC_PF 2
`define EXEC_AF 4
`define EXEC_ZF 6
`define EXEC_SF 7
`define EXEC_DF 10
`define EXEC_OF 11

// Stack step of CALL and RET in bytes
`define EXEC_SLOT_BYTES 4

`endif

// File: logic/exec_pkg.sv
//////////////////////////////////////////////////
// Execute stage types
// Vector typedefs, op enum, micro-op and results
//////////////////////////////////////////////////
`include "exec_cfg.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;
    typedef logic [1:0]            opsize_t;
    typedef logic [`EXEC_OF:0]     flags_t;
    typedef logic [1:0]            cond_t;

    // Operand sizes
    localparam opsize_t size_byte  = 2'd0;
    localparam opsize_t size_word  = 2'd1;
    localparam opsize_t size_dword = 2'd2;

    // Jump conditions
    localparam cond_t cond_c  = 2'd0;
    localparam cond_t cond_nc = 2'd1;
    localparam cond_t cond_z  = 2'd2;
    localparam cond_t cond_nz = 2'd3;

    typedef enum logic [4:0] {
        op_add, op_and, op_or, op_not, op_sal, op_sar,
        op_mov, op_cmovc, op_xchg, op_movs, op_push, op_pop,
        op_call_near, op_ret, op_jmp_near, op_jcc, op_cld, op_std
    } op_e;

    typedef struct packed {
        op_e     op;
        opsize_t size;
        cond_t   cond;
        logic    imm;          // RET with immediate in op2
        word_t   op1;          // Destination value or popped return address
        word_t   op2;          // Source, displacement or immediate
        word_t   op3;          // Destination index
        word_t   op4;          // Stack pointer
        word_t   dest1;
        word_t   dest2;
        word_t   dest3;
        word_t   dest4;
        word_t   eip;
        word_t   next_eip;
        logic    pred_taken;
        word_t   pred_target;
    } uop_t;

    typedef struct packed {
        word_t value;
        word_t dest;
        logic  wb;
    } wb_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  correct;
        word_t fip;            // Fetch restart address
    } br_t;

endpackage

// File: logic/int_alu.sv
//////////////////////////////////////////////////
// Integer ALU of the execute stage
// Result, new flag values and flag write mask
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "exec_cfg.svh"

module int_alu (
    input  exec_pkg::uop_t   uop,
    input  exec_pkg::flags_t flags,
    output exec_pkg::wb_t    res1,
    output exec_pkg::flags_t new_flags,
    output exec_pkg::flags_t flag_mask
);

    exec_pkg::word_t         size_mask;
    exec_pkg::word_t         a;
    exec_pkg::word_t         b;
    exec_pkg::word_t         a_sext;
    exec_pkg::word_t         result;
    logic [`EXEC_XLEN:0]     sum;
    logic [2*`EXEC_XLEN-1:0] sal_ext;
    logic [`EXEC_XLEN:0]     sar_ext;
    logic [4:0]              count;
    logic [5:0]              width;
    logic [4:0]              msb;
    logic                    cf;
    logic                    of;
    logic                    wr;

    // Operands cut to the operand size
    always_comb begin
        case (uop.size)
            exec_pkg::size_byte: begin
                size_mask = exec_pkg::word_t'(8'hff);
                width     = 6'd8;
            end
            exec_pkg::size_word: begin
                size_mask = exec_pkg::word_t'(16'hffff);
                width     = 6'd16;
            end
            default: begin
                size_mask = '1;
                width     = 6'd32;
            end
        endcase
        msb     = 5'(width - 6'd1);
        a       = uop.op1 & size_mask;
        b       = uop.op2 & size_mask;
        count   = uop.op2[4:0];
        sum     = {1'b0, a} + {1'b0, b};
        a_sext  = a | (a[msb] ? ~size_mask : '0);   // Sign extend for SAR
        sal_ext = {{`EXEC_XLEN{1'b0}}, a} << count;
        sar_ext = $signed({a_sext, 1'b0}) >>> count; // Extra low bit catches CF
    end

    always_comb begin
        result    = '0;
        wr        = 1'b0;
        cf        = 1'b0;
        of        = 1'b0;
        flag_mask = '0;
        new_flags = flags;
        case (uop.op)
            exec_pkg::op_add: begin
                result = sum[`EXEC_XLEN-1:0];
                cf     = sum[width];
                of     = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
                wr     = 1'b1;
                flag_mask[`EXEC_CF] = 1'b1;
                flag_mask[`EXEC_PF] = 1'b1;
                flag_mask[`EXEC_AF] = 1'b1;
                flag_mask[`EXEC_ZF] = 1'b1;
                flag_mask[`EXEC_SF] = 1'b1;
                flag_mask[`EXEC_OF] = 1'b1;
            end
            exec_pkg::op_and, exec_pkg::op_or: begin
                result = (uop.op == exec_pkg::op_and) ? (a & b) : (a | b);
                wr     = 1'b1;
                flag_mask[`EXEC_CF] = 1'b1;     // Cleared
                flag_mask[`EXEC_OF] = 1'b1;
                flag_mask[`EXEC_PF] = 1'b1;
                flag_mask[`EXEC_ZF] = 1'b1;
                flag_mask[`EXEC_SF] = 1'b1;
            end
            exec_pkg::op_not: begin
                result = ~a;                    // NOT leaves flags alone
                wr     = 1'b1;
            end
            exec_pkg::op_sal, exec_pkg::op_sar: begin
                if (uop.op == exec_pkg::op_sal) begin
                    result = sal_ext[`EXEC_XLEN-1:0];
                    cf     = sal_ext[width];
                end else begin
                    result = sar_ext[`EXEC_XLEN:1];
                    cf     = sar_ext[0];
                end
                wr = 1'b1;
                // Zero count keeps flags
                if (count != 5'd0) begin
                    flag_mask[`EXEC_CF] = 1'b1;
                    flag_mask[`EXEC_PF] = 1'b1;
                    flag_mask[`EXEC_ZF] = 1'b1;
                    flag_mask[`EXEC_SF] = 1'b1;
                end
            end
            exec_pkg::op_mov, exec_pkg::op_cmovc, exec_pkg::op_xchg: begin
                result = b;
                wr     = 1'b1;
            end
            exec_pkg::op_call_near: begin
                result = uop.next_eip;          // Return address to the stack
                wr     = 1'b1;
            end
            exec_pkg::op_cld, exec_pkg::op_std: begin
                flag_mask[`EXEC_DF] = 1'b1;
                new_flags[`EXEC_DF] = (uop.op == exec_pkg::op_std);
            end
            default: ;
        endcase
        result = result & size_mask;
        new_flags[`EXEC_CF] = cf;
        new_flags[`EXEC_PF] = ~^result[7:0];
        new_flags[`EXEC_AF] = a[4] ^ b[4] ^ result[4];
        new_flags[`EXEC_ZF] = (result == '0);
        new_flags[`EXEC_SF] = result[msb];
        new_flags[`EXEC_OF] = of;

        // Only CLD and STD may touch DF
        a_df_mask: assert (!flag_mask[`EXEC_DF] ||
                           uop.op inside {exec_pkg::op_cld, exec_pkg::op_std});
    end

    assign res1 = '{value: result, dest: uop.dest1, wb: wr};

endmodule

// File: logic/ptr_update.sv
//////////////////////////////////////////////////
// String and stack pointer updates
// MOVS source and destination, stack pointer
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "exec_cfg.svh"

module ptr_update (
    input  exec_pkg::uop_t   uop,
    input  exec_pkg::flags_t flags,
    output exec_pkg::wb_t    res2,
    output exec_pkg::wb_t    res3,
    output exec_pkg::wb_t    res4
);

    localparam exec_pkg::word_t slot_bytes = exec_pkg::word_t'(`EXEC_SLOT_BYTES);

    exec_pkg::word_t nbytes;
    exec_pkg::word_t str_step;
    exec_pkg::word_t ret_pop;

    always_comb begin
        case (uop.size)
            exec_pkg::size_byte: nbytes = exec_pkg::word_t'(1);
            exec_pkg::size_word: nbytes = exec_pkg::word_t'(2);
            default:             nbytes = exec_pkg::word_t'(4);
        endcase
        str_step = flags[`EXEC_DF] ? -nbytes : nbytes;          // DF set walks down
        ret_pop  = slot_bytes + (uop.imm ? uop.op2 : '0);       // RET imm frees arguments
    end

    // Source pointer, or op1 for the XCHG swap
    always_comb begin
        res2 = '{value: uop.op2, dest: uop.dest2, wb: 1'b0};
        case (uop.op)
            exec_pkg::op_movs: begin
                res2.value = uop.op2 + str_step;
                res2.wb    = 1'b1;
            end
            exec_pkg::op_xchg: begin
                res2.value = uop.op1;
                res2.wb    = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        res3 = '{value: uop.op3, dest: uop.dest3, wb: 1'b0};
        if (uop.op == exec_pkg::op_movs) begin
            res3.value = uop.op3 + str_step;   // Destination index
            res3.wb    = 1'b1;
        end
    end

    // Stack pointer
    always_comb begin
        res4 = '{value: uop.op4, dest: uop.dest4, wb: 1'b1};
        case (uop.op)
            exec_pkg::op_push:      res4.value = uop.op4 - nbytes;
            exec_pkg::op_call_near: res4.value = uop.op4 - slot_bytes;
            exec_pkg::op_pop:       res4.value = uop.op4 + nbytes;
            exec_pkg::op_ret:       res4.value = uop.op4 + ret_pop;
            default:                res4.wb    = 1'b0;
        endcase
    end

endmodule

// File: logic/flags_reg.sv
//////////////////////////////////////////////////
// Architectural flags register
// Masked update, cleared on reset
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "exec_cfg.svh"

module flags_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flags_we,
    input  exec_pkg::flags_t new_flags,
    input  exec_pkg::flags_t flag_mask,
    output exec_pkg::flags_t flags
);

    // Bits that hold a real flag
    localparam exec_pkg::flags_t live_bits = (exec_pkg::flags_t'(1) << `EXEC_CF) |
                                             (exec_pkg::flags_t'(1) << `EXEC_PF) |
                                             (exec_pkg::flags_t'(1) << `EXEC_AF) |
                                             (exec_pkg::flags_t'(1) << `EXEC_ZF) |
                                             (exec_pkg::flags_t'(1) << `EXEC_SF) |
                                             (exec_pkg::flags_t'(1) << `EXEC_DF) |
                                             (exec_pkg::flags_t'(1) << `EXEC_OF);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flags_we) begin
            flags <= (flags & ~flag_mask) | (new_flags & flag_mask);
        end
    end

    // Reserved positions stay clear through every update
    a_reserved_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (flags & ~live_bits) == '0);

endmodule

// File: logic/flow_control.sv
//////////////////////////////////////////////////
// Accept, CMOVC skip and branch resolution
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "exec_cfg.svh"

module flow_control (
    input  logic             valid_in,
    input  logic             latch_empty,
    input  exec_pkg::uop_t   uop,
    input  exec_pkg::flags_t flags,
    output logic             valid_out,
    output logic             flags_we,
    output exec_pkg::br_t    br
);

    logic            accepted;
    logic            skip;
    logic            is_branch;
    logic            cond_met;
    logic            taken;
    exec_pkg::word_t target;

    assign accepted = valid_in & ~latch_empty;

    always_comb begin
        case (uop.cond)
            exec_pkg::cond_c:  cond_met = flags[`EXEC_CF];
            exec_pkg::cond_nc: cond_met = !flags[`EXEC_CF];
            exec_pkg::cond_z:  cond_met = flags[`EXEC_ZF];
            default:           cond_met = !flags[`EXEC_ZF];   // nz
        endcase

        skip      = (uop.op == exec_pkg::op_cmovc) && !flags[`EXEC_CF];
        is_branch = uop.op inside {exec_pkg::op_jmp_near, exec_pkg::op_jcc,
                                   exec_pkg::op_call_near, exec_pkg::op_ret};
        taken     = is_branch && ((uop.op != exec_pkg::op_jcc) || cond_met);

        // RET goes to the popped address and other branches are relative
        target = (uop.op == exec_pkg::op_ret) ? uop.op1 : uop.next_eip + uop.op2;

        valid_out  = accepted & ~skip;
        flags_we   = accepted & ~skip;
        br.valid   = accepted & is_branch;
        br.taken   = taken;
        br.fip     = taken ? target : uop.next_eip;
        br.correct = (taken == uop.pred_taken) &&
                     (!taken || (target == uop.pred_target));

        // No branch report for an op that was not issued
        a_br_needs_valid: assert (!br.valid || valid_out);
    end

endmodule

// File: logic/execute_top.sv
//////////////////////////////////////////////////
// Execute stage top level
// ALU, pointer updates, flags and branch logic
//////////////////////////////////////////////////
`timescale 1ns/1ns

module execute_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    input  logic             latch_empty,
    input  exec_pkg::uop_t   uop,
    output logic             valid_out,
    output exec_pkg::wb_t    res1,
    output exec_pkg::wb_t    res2,
    output exec_pkg::wb_t    res3,
    output exec_pkg::wb_t    res4,
    output exec_pkg::br_t    br,
    output exec_pkg::flags_t eflags
);

    exec_pkg::flags_t flags;
    exec_pkg::flags_t new_flags;
    exec_pkg::flags_t flag_mask;
    exec_pkg::wb_t    alu_res1;
    exec_pkg::wb_t    ptr_res2;
    exec_pkg::wb_t    ptr_res3;
    exec_pkg::wb_t    ptr_res4;
    logic             flags_we;

    int_alu i_int_alu (
        .uop       (uop),
        .flags     (flags),
        .res1      (alu_res1),
        .new_flags (new_flags),
        .flag_mask (flag_mask)
    );

    ptr_update i_ptr_update (
        .uop   (uop),
        .flags (flags),
        .res2  (ptr_res2),
        .res3  (ptr_res3),
        .res4  (ptr_res4)
    );

    flags_reg i_flags_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flags_we  (flags_we),
        .new_flags (new_flags),
        .flag_mask (flag_mask),
        .flags     (flags)
    );

    flow_control i_flow_control (
        .valid_in    (valid_in),
        .latch_empty (latch_empty),
        .uop         (uop),
        .flags       (flags),
        .valid_out   (valid_out),
        .flags_we    (flags_we),
        .br          (br)
    );

    // Write-backs only for an issued op
    assign res1 = '{value: alu_res1.value, dest: alu_res1.dest, wb: alu_res1.wb & valid_out};
    assign res2 = '{value: ptr_res2.value, dest: ptr_res2.dest, wb: ptr_res2.wb & valid_out};
    assign res3 = '{value: ptr_res3.value, dest: ptr_res3.dest, wb: ptr_res3.wb & valid_out};
    assign res4 = '{value: ptr_res4.value, dest: ptr_res4.dest, wb: ptr_res4.wb & valid_out};

    assign eflags = flags;

endmodule

// File: testbench/tb_execute.sv
//////////////////////////////////////////////////
// Testbench of the execute stage
// LFSR stimulus, reference model, output checks
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "exec_cfg.svh"

module tb_execute;

    localparam int max_cycles = 5000;
    localparam int wait_limit = 4;
    localparam exec_pkg::op_e alu_ops [8] = '{exec_pkg::op_add, exec_pkg::op_and,
        exec_pkg::op_or, exec_pkg::op_not, exec_pkg::op_sal, exec_pkg::op_sar,
        exec_pkg::op_mov, exec_pkg::op_xchg};

    logic             clk;
    logic             rst_n;
    logic             valid_in;
    logic             latch_empty;
    exec_pkg::uop_t   uop;
    logic             valid_out;
    exec_pkg::wb_t    res1, res2, res3, res4;
    exec_pkg::br_t    br;
    exec_pkg::flags_t eflags;

    exec_pkg::flags_t mflags;              // Model copy of the flags
    exec_pkg::wb_t    exp_res1, exp_res2, exp_res3, exp_res4;
    exec_pkg::br_t    exp_br;
    exec_pkg::word_t  nbytes, step, target;
    logic             exp_valid, hold, br_taken;
    logic [31:0]      lfsr_state = 32'h9d9ee360;
    int               errors = 0;
    int               start_errors, ops, tests_ok, tests_bad;

    execute_top i_execute_top (
        .clk (clk), .rst_n (rst_n), .valid_in (valid_in), .latch_empty (latch_empty),
        .uop (uop), .valid_out (valid_out), .res1 (res1), .res2 (res2), .res3 (res3),
        .res4 (res4), .br (br), .eflags (eflags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    function automatic int width_of(exec_pkg::opsize_t s);
        case (s)
            2'd0:    return 8;
            2'd1:    return 16;
            default: return 32;
        endcase
    endfunction

    function automatic exec_pkg::word_t mask_of(exec_pkg::opsize_t s);
        int w;
        w = width_of(s);
        return (w == 32) ? '1 : (exec_pkg::word_t'(1) << w) - 1;
    endfunction

    // Shift one bit at a time so carry is the last bit out
    function automatic exec_pkg::word_t shift_ref(exec_pkg::uop_t u, output logic carry);
        exec_pkg::word_t r;
        int w, i, cnt;
        w = width_of(u.size);
        r = u.op1 & mask_of(u.size);
        cnt = {27'd0, u.op2[4:0]};
        carry = 1'b0;
        for (i = 0; i < cnt; i++) begin
            if (u.op == exec_pkg::op_sal) begin
                carry = r[w-1];
                r = (r << 1) & mask_of(u.size);
            end else begin
                carry = r[0];
                r = (r >> 1) | (exec_pkg::word_t'(r[w-1]) << (w - 1));
            end
        end
        return r;
    endfunction

    function automatic exec_pkg::word_t alu_value(exec_pkg::uop_t u);
        exec_pkg::word_t r;
        logic c;
        case (u.op)
            exec_pkg::op_add:       r = u.op1 + u.op2;
            exec_pkg::op_and:       r = u.op1 & u.op2;
            exec_pkg::op_or:        r = u.op1 | u.op2;
            exec_pkg::op_not:       r = ~u.op1;
            exec_pkg::op_sal,
            exec_pkg::op_sar:       r = shift_ref(u, c);
            exec_pkg::op_mov,
            exec_pkg::op_cmovc,
            exec_pkg::op_xchg:      r = u.op2;
            exec_pkg::op_call_near: r = u.next_eip;
            default:                r = '0;
        endcase
        return r & mask_of(u.size);
    endfunction

    function automatic exec_pkg::flags_t result_flags(exec_pkg::flags_t f,
                                                      exec_pkg::word_t r, int w);
        f[`EXEC_PF] = ~^r[7:0];            // Even parity of the low byte
        f[`EXEC_ZF] = (r == '0);
        f[`EXEC_SF] = r[w-1];
        return f;
    endfunction

    function automatic exec_pkg::flags_t flags_after(exec_pkg::uop_t u, exec_pkg::flags_t f);
        exec_pkg::word_t a, b, r;
        logic [63:0] sum;
        logic c;
        int w;
        w = width_of(u.size);
        a = u.op1 & mask_of(u.size);
        b = u.op2 & mask_of(u.size);
        r = alu_value(u);
        sum = {32'd0, a} + {32'd0, b};
        case (u.op)
            exec_pkg::op_add: begin
                f[`EXEC_CF] = sum[w];
                f[`EXEC_AF] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
                f[`EXEC_OF] = (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]);
                f = result_flags(f, r, w);
            end
            exec_pkg::op_and, exec_pkg::op_or: begin
                f[`EXEC_CF] = 1'b0;
                f[`EXEC_OF] = 1'b0;
                f = result_flags(f, r, w);
            end
            exec_pkg::op_sal, exec_pkg::op_sar: begin
                if (u.op2[4:0] != 5'd0) begin
                    r = shift_ref(u, c);
                    f[`EXEC_CF] = c;
                    f = result_flags(f, r, w);
                end
            end
            exec_pkg::op_cld: f[`EXEC_DF] = 1'b0;
            exec_pkg::op_std: f[`EXEC_DF] = 1'b1;
            default: ;
        endcase
        return f;
    endfunction

    // Expected outputs for the op on the inputs now
    always_comb begin
        exp_valid = valid_in && !latch_empty &&
                    !(uop.op == exec_pkg::op_cmovc && !mflags[`EXEC_CF]);
        nbytes = exec_pkg::word_t'(width_of(uop.size) / 8);
        step   = mflags[`EXEC_DF] ? -nbytes : nbytes;
        exp_res1 = '{value: alu_value(uop), dest: uop.dest1, wb: exp_valid &&
                     uop.op inside {exec_pkg::op_add, exec_pkg::op_and, exec_pkg::op_or,
                                    exec_pkg::op_not, exec_pkg::op_sal, exec_pkg::op_sar,
                                    exec_pkg::op_mov, exec_pkg::op_cmovc, exec_pkg::op_xchg,
                                    exec_pkg::op_call_near}};
        exp_res2 = '{value: uop.op2, dest: uop.dest2, wb: 1'b0};
        exp_res3 = '{value: uop.op3, dest: uop.dest3, wb: 1'b0};
        exp_res4 = '{value: uop.op4, dest: uop.dest4, wb: exp_valid};
        if (uop.op == exec_pkg::op_movs) begin
            exp_res2 = '{value: uop.op2 + step, dest: uop.dest2, wb: exp_valid};
            exp_res3 = '{value: uop.op3 + step, dest: uop.dest3, wb: exp_valid};
        end
        if (uop.op == exec_pkg::op_xchg) begin
            exp_res2 = '{value: uop.op1, dest: uop.dest2, wb: exp_valid};
        end
        case (uop.op)
            exec_pkg::op_push:      exp_res4.value = uop.op4 - nbytes;
            exec_pkg::op_pop:       exp_res4.value = uop.op4 + nbytes;
            exec_pkg::op_call_near: exp_res4.value = uop.op4 - `EXEC_SLOT_BYTES;
            exec_pkg::op_ret:
                exp_res4.value = uop.op4 + `EXEC_SLOT_BYTES + (uop.imm ? uop.op2 : '0);
            default:                exp_res4.wb = 1'b0;
        endcase
        case (uop.cond)
            exec_pkg::cond_c:  hold = mflags[`EXEC_CF];
            exec_pkg::cond_nc: hold = !mflags[`EXEC_CF];
            exec_pkg::cond_z:  hold = mflags[`EXEC_ZF];
            default:           hold = !mflags[`EXEC_ZF];
        endcase
        br_taken = (uop.op == exec_pkg::op_jcc) ? hold : 1'b1;
        target   = (uop.op == exec_pkg::op_ret) ? uop.op1 : uop.next_eip + uop.op2;
        exp_br.valid   = exp_valid && uop.op inside {exec_pkg::op_jmp_near, exec_pkg::op_jcc,
                                                     exec_pkg::op_call_near, exec_pkg::op_ret};
        exp_br.taken   = br_taken;
        exp_br.fip     = br_taken ? target : uop.next_eip;
        exp_br.correct = (br_taken == uop.pred_taken) &&
                         (!br_taken || target == uop.pred_target);
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            mflags <= '0;
        end else if (exp_valid) begin
            mflags <= flags_after(uop, mflags);   // Seen one cycle later
        end
    end

    function automatic logic wb_match(exec_pkg::wb_t e, exec_pkg::wb_t a);
        return (a.wb == e.wb) && (!e.wb || a == e);
    endfunction

    a_valid_out: assert property (@(negedge clk) disable iff (!rst_n) valid_out == exp_valid)
        else begin
            $display("[FAIL] valid_out expected %h actual %h", exp_valid, valid_out);
            errors++;
        end
    a_res1: assert property (@(negedge clk) disable iff (!rst_n) wb_match(exp_res1, res1))
        else begin
            $display("[FAIL] res1 expected %h actual %h", exp_res1, res1);
            errors++;
        end
    a_res2: assert property (@(negedge clk) disable iff (!rst_n) wb_match(exp_res2, res2))
        else begin
            $display("[FAIL] res2 expected %h actual %h", exp_res2, res2);
            errors++;
        end
    a_res3: assert property (@(negedge clk) disable iff (!rst_n) wb_match(exp_res3, res3))
        else begin
            $display("[FAIL] res3 expected %h actual %h", exp_res3, res3);
            errors++;
        end
    a_res4: assert property (@(negedge clk) disable iff (!rst_n) wb_match(exp_res4, res4))
        else begin
            $display("[FAIL] res4 expected %h actual %h", exp_res4, res4);
            errors++;
        end
    a_br: assert property (@(negedge clk) disable iff (!rst_n)
        br.valid == exp_br.valid && (!exp_br.valid || br == exp_br))
        else begin
            $display("[FAIL] br expected %h actual %h", exp_br, br);
            errors++;
        end
    a_eflags: assert property (@(negedge clk) disable iff (!rst_n) eflags == mflags)
        else begin
            $display("[FAIL] eflags expected %h actual %h", mflags, eflags);
            errors++;
        end

    function automatic exec_pkg::uop_t rand_uop(exec_pkg::op_e op, exec_pkg::opsize_t size);
        exec_pkg::uop_t u;
        u = '0;
        u.op          = op;
        u.size        = size;
        u.cond        = exec_pkg::cond_t'(rand_bits(2));
        u.imm         = rand_bit();
        u.op1         = rand_bits(32);
        u.op2         = rand_bits(32);
        u.op3         = rand_bits(32);
        u.op4         = rand_bits(32);
        u.dest1       = rand_bits(32);
        u.dest2       = rand_bits(32);
        u.dest3       = rand_bits(32);
        u.dest4       = rand_bits(32);
        u.eip         = rand_bits(32);
        u.next_eip    = rand_bits(32);
        u.pred_taken  = rand_bit();
        u.pred_target = rand_bits(32);
        return u;
    endfunction

    task automatic issue(exec_pkg::uop_t u, logic vin, logic busy);
        int t;
        @(posedge clk);
        uop         <= u;
        valid_in    <= vin;
        latch_empty <= busy;
        @(negedge clk);
        ops++;
        t = 0;
        while (exp_valid && !valid_out && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (exp_valid && !valid_out) begin
            $display("stage never raised valid_out for op %s", u.op.name());
            errors++;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        valid_in    <= 1'b0;
        latch_empty <= 1'b0;
        @(negedge clk);
    endtask

    // Byte adds that leave CF and ZF as asked
    task automatic set_cz(logic c, logic z);
        exec_pkg::uop_t u;
        u = rand_uop(exec_pkg::op_add, exec_pkg::size_byte);
        u.op1 = c ? 32'hff : (z ? 32'h00 : 32'h01);
        u.op2 = c ? (z ? 32'h01 : 32'h02) : (z ? 32'h00 : 32'h01);
        issue(u, 1'b1, 1'b0);
    endtask

    task automatic begin_test();
        start_errors = errors;
        ops = 0;
    endtask

    task automatic end_test(string name);
        idle();
        if (errors == start_errors) tests_ok++;
        else tests_bad++;
        $display("%s: %0d ops, %0d errors", name, ops, errors - start_errors);
    endtask

    initial begin
        int c;
        for (c = 0; c < max_cycles; c++) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        exec_pkg::uop_t u;
        int o, s, k, cnd, good;
        logic cond_true;
        rst_n = 1'b0;
        valid_in = 1'b0;
        latch_empty = 1'b0;
        uop = '0;
        tests_ok = 0;
        tests_bad = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        idle();

        begin_test();
        for (o = 0; o < 8; o++) for (s = 0; s < 3; s++) for (k = 0; k < 4; k++)
            issue(rand_uop(alu_ops[o], exec_pkg::opsize_t'(s)), 1'b1, 1'b0);
        end_test("alu ops");

        begin_test();
        set_cz(1'b1, 1'b1);
        issue(rand_uop(exec_pkg::op_add, exec_pkg::size_dword), 1'b1, 1'b1);  // Latch busy
        issue(rand_uop(exec_pkg::op_std, exec_pkg::size_dword), 1'b0, 1'b0);  // Nothing valid
        issue(rand_uop(exec_pkg::op_add, exec_pkg::size_word), 1'b1, 1'b0);
        issue(rand_uop(exec_pkg::op_and, exec_pkg::size_byte), 1'b1, 1'b0);
        end_test("flags");

        begin_test();
        for (k = 0; k < 2; k++) begin
            issue(rand_uop(k ? exec_pkg::op_std : exec_pkg::op_cld, exec_pkg::size_dword),
                  1'b1, 1'b0);
            for (s = 0; s < 3; s++)
                issue(rand_uop(exec_pkg::op_movs, exec_pkg::opsize_t'(s)), 1'b1, 1'b0);
        end
        issue(rand_uop(exec_pkg::op_cld, exec_pkg::size_dword), 1'b1, 1'b0);
        end_test("movs");

        begin_test();
        for (s = 0; s < 3; s++) begin
            issue(rand_uop(exec_pkg::op_push, exec_pkg::opsize_t'(s)), 1'b1, 1'b0);
            issue(rand_uop(exec_pkg::op_pop, exec_pkg::opsize_t'(s)), 1'b1, 1'b0);
        end
        issue(rand_uop(exec_pkg::op_call_near, exec_pkg::size_dword), 1'b1, 1'b0);
        for (k = 0; k < 2; k++) begin
            u = rand_uop(exec_pkg::op_ret, exec_pkg::size_dword);
            u.imm = k[0];
            issue(u, 1'b1, 1'b0);
        end
        end_test("stack");

        begin_test();
        for (k = 0; k < 4; k++) begin
            set_cz(k[1], k[0]);
            for (cnd = 0; cnd < 4; cnd++) for (good = 0; good < 3; good++) begin
                u = rand_uop(exec_pkg::op_jcc, exec_pkg::size_dword);
                u.cond = exec_pkg::cond_t'(cnd);
                cond_true = (cnd == 0) ? k[1] : (cnd == 1) ? !k[1] :
                            (cnd == 2) ? k[0] : !k[0];
                u.pred_taken  = (good == 0) ? !cond_true : cond_true;
                u.pred_target = u.next_eip + u.op2 + ((good == 2) ? 32'd4 : 32'd0);
                issue(u, 1'b1, 1'b0);
            end
        end
        issue(rand_uop(exec_pkg::op_jmp_near, exec_pkg::size_dword), 1'b1, 1'b0);
        u = rand_uop(exec_pkg::op_ret, exec_pkg::size_dword);
        u.pred_taken  = 1'b1;
        u.pred_target = u.op1;                 // Return stack hit
        issue(u, 1'b1, 1'b0);
        end_test("branch");

        begin_test();
        for (k = 0; k < 2; k++) begin
            set_cz(k[0], 1'b0);
            issue(rand_uop(exec_pkg::op_cmovc, exec_pkg::opsize_t'(k + 1)), 1'b1, 1'b0);
        end
        end_test("cmovc");

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: execute_top.f
+incdir+logic
logic/exec_pkg.sv
logic/int_alu.sv
logic/ptr_update.sv
logic/flags_reg.sv
logic/flow_control.sv
logic/execute_top.sv
testbench/tb_execute.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_execute
FILELIST  ?= execute_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The run passes only if the pass message shows up on a line of its own
test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
